// File: Bender.yml
package:
  name: mc_cache_tile

sources:
  - logic/mc_cache_pkg.sv
  - logic/mc_request_fifo.sv
  - logic/mc_link_to_cache.sv
  - logic/mc_cache_store.sv
  - logic/mc_cache_tile.sv
  - target: test
    files:
      - tests/mc_cache_chk.sv
      - tests/tb_mc_cache_tile.sv

// File: list.f
logic/mc_cache_pkg.sv
logic/mc_request_fifo.sv
logic/mc_link_to_cache.sv
logic/mc_cache_store.sv
logic/mc_cache_tile.sv
tests/mc_cache_chk.sv
tests/tb_mc_cache_tile.sv

// File: logic/mc_cache_pkg.sv
`default_nettype none

package mc_cache_pkg;

  localparam int addr_width_gp = 12;
  localparam int data_width_gp = 32;
  localparam int cord_width_gp = 4;
  localparam int reg_id_width_gp = 5;
  localparam int mask_width_gp = data_width_gp / 8;
  // word address plus byte offset
  localparam int cache_addr_width_gp = addr_width_gp + $clog2(mask_width_gp);

  typedef enum logic [2:0] {
    e_mc_store,
    e_mc_sw,
    e_mc_load,
    e_mc_cache_op,
    e_mc_amoswap,
    e_mc_amoor
  } mc_op_e;

  typedef enum logic [1:0] {
    e_afl,
    e_aflinv,
    e_ainv
  } cache_op_e;

  typedef struct packed {
    logic icache_fetch;
    logic float_wb;
    logic is_byte_op;
    logic is_hex_op;
    logic is_unsigned_op;
    // byte select within the word
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    mc_op_e op;
    logic [addr_width_gp-1:0] addr;
    logic [data_width_gp-1:0] payload;
    logic [mask_width_gp-1:0] mask;
    logic [reg_id_width_gp-1:0] reg_id;
    cache_op_e cache_op;
    load_info_s load_info;
    logic [cord_width_gp-1:0] src_x;
    logic [cord_width_gp-1:0] src_y;
  } mc_request_s;

  typedef enum logic [1:0] {
    e_ret_credit,
    e_ret_int_wb,
    e_ret_float_wb,
    e_ret_ifetch
  } ret_type_e;

  typedef struct packed {
    ret_type_e pkt_type;
    logic [data_width_gp-1:0] data;
    logic [reg_id_width_gp-1:0] reg_id;
    logic [cord_width_gp-1:0] src_x;
    logic [cord_width_gp-1:0] src_y;
  } mc_return_s;

  typedef enum logic [3:0] {
    TAGST,
    TAGLA,
    TAGFL,
    SM,
    LB,
    LBU,
    LH,
    LHU,
    LW,
    AMOSWAP_W,
    AMOOR_W,
    AFL,
    AFLINV,
    AINV
  } cache_opcode_e;

  typedef struct packed {
    cache_opcode_e opcode;
    logic [cache_addr_width_gp-1:0] addr;
    logic [data_width_gp-1:0] data;
    logic [mask_width_gp-1:0] mask;
  } cache_pkt_s;

endpackage

`default_nettype wire

// File: logic/mc_cache_store.sv
`timescale 1ns/1ps
`default_nettype none

module mc_cache_store #(
  parameter int sets_p = 4,
  parameter int ways_p = 2,
  parameter int block_size_in_words_p = 4
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  mc_cache_pkg::cache_pkt_s               pkt_i,
  input  logic                                   v_i,
  output logic                                   ready_o,
  output logic [mc_cache_pkg::data_width_gp-1:0] data_o,
  output logic                                   v_o,
  input  logic                                   yumi_i,
  output logic                                   v_we_o
);
  import mc_cache_pkg::*;

  localparam int byte_off_width_lp = $clog2(mask_width_gp);
  localparam int tag_els_lp = sets_p * ways_p;
  localparam int data_els_lp = tag_els_lp * block_size_in_words_p;
  localparam int lg_tag_els_lp = (tag_els_lp > 1) ? $clog2(tag_els_lp) : 1;
  localparam int lg_data_els_lp = (data_els_lp > 1) ? $clog2(data_els_lp) : 1;
  localparam int block_offset_width_lp = byte_off_width_lp + $clog2(block_size_in_words_p);

  logic [data_width_gp-1:0] data_mem [data_els_lp];
  logic [data_width_gp-1:0] tag_mem [tag_els_lp];

  logic tl_v_r, tv_v_r, tv_ready;
  cache_pkt_s tl_pkt_r;
  logic [data_width_gp-1:0] tv_data_r;

  logic [lg_data_els_lp-1:0] d_idx;
  logic [lg_tag_els_lp-1:0] t_idx;
  logic [byte_off_width_lp-1:0] byte_off;
  logic [data_width_gp-1:0] rd_word, wr_word, result;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;
  logic data_we, tag_we;

  // verify stage frees up on yumi, lookup stage follows it
  assign tv_ready = ~tv_v_r | yumi_i;
  assign v_we_o = tl_v_r & tv_ready;
  assign ready_o = ~tl_v_r | v_we_o;
  assign v_o = tv_v_r;
  assign data_o = tv_data_r;

  assign d_idx = tl_pkt_r.addr[byte_off_width_lp+:lg_data_els_lp];
  assign t_idx = tl_pkt_r.addr[block_offset_width_lp+:lg_tag_els_lp];
  assign byte_off = tl_pkt_r.addr[byte_off_width_lp-1:0];
  assign rd_word = data_mem[d_idx];
  assign ld_byte = rd_word[{byte_off, 3'b000}+:8];
  assign ld_half = rd_word[{byte_off[1], 4'b0000}+:16];

  always_comb begin
    result = '0;
    wr_word = rd_word;
    data_we = 1'b0;
    tag_we = 1'b0;
    unique case (tl_pkt_r.opcode)
      LB: result = {{(data_width_gp-8){ld_byte[7]}}, ld_byte};
      LBU: result = {{(data_width_gp-8){1'b0}}, ld_byte};
      LH: result = {{(data_width_gp-16){ld_half[15]}}, ld_half};
      LHU: result = {{(data_width_gp-16){1'b0}}, ld_half};
      LW: result = rd_word;
      SM: begin
        data_we = 1'b1;
        for (int i = 0; i < mask_width_gp; i++) begin
          if (tl_pkt_r.mask[i]) begin
            wr_word[8*i+:8] = tl_pkt_r.data[8*i+:8];
          end
        end
      end
      AMOSWAP_W: begin
        result = rd_word;
        wr_word = tl_pkt_r.data;
        data_we = 1'b1;
      end
      AMOOR_W: begin
        result = rd_word;
        wr_word = rd_word | tl_pkt_r.data;
        data_we = 1'b1;
      end
      TAGST: tag_we = 1'b1;
      TAGLA: result = tag_mem[t_idx];
      // flush and invalidate only return a credit
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (ready_o & v_i) begin
      tl_pkt_r <= pkt_i;
    end
    if (v_we_o) begin
      tv_data_r <= result;
      if (data_we) begin
        data_mem[d_idx] <= wr_word;
      end
      if (tag_we) begin
        tag_mem[t_idx] <= tl_pkt_r.data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
    end else begin
      if (ready_o) begin
        tl_v_r <= v_i;
      end
      if (tv_ready) begin
        tv_v_r <= tl_v_r;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/mc_cache_tile.sv
`timescale 1ns/1ps
`default_nettype none

module mc_cache_tile #(
  parameter int sets_p = 4,
  parameter int ways_p = 2,
  parameter int block_size_in_words_p = 4,
  parameter int fifo_els_p = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mc_cache_pkg::mc_request_s req_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,
  output mc_cache_pkg::mc_return_s  ret_o,
  output logic                      ret_v_o,
  input  logic                      ret_ready_i
);
  import mc_cache_pkg::*;

  mc_request_s fifo_data;
  logic fifo_v, fifo_yumi;

  cache_pkt_s cache_pkt;
  logic cache_pkt_v, cache_ready;
  logic [data_width_gp-1:0] cache_data;
  logic cache_v, cache_yumi, cache_v_we;

  mc_request_fifo #(
    .els_p(fifo_els_p)
  ) req_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i(req_i),
    .v_i(req_v_i),
    .ready_o(req_ready_o),
    .data_o(fifo_data),
    .v_o(fifo_v),
    .yumi_i(fifo_yumi)
  );

  mc_link_to_cache #(
    .sets_p(sets_p),
    .ways_p(ways_p),
    .block_size_in_words_p(block_size_in_words_p)
  ) link (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_i(fifo_data),
    .req_v_i(fifo_v),
    .req_yumi_o(fifo_yumi),
    .cache_pkt_o(cache_pkt),
    .v_o(cache_pkt_v),
    .ready_i(cache_ready),
    .data_i(cache_data),
    .v_i(cache_v),
    .yumi_o(cache_yumi),
    .v_we_i(cache_v_we),
    .ret_o(ret_o),
    .ret_v_o(ret_v_o),
    .ret_ready_i(ret_ready_i)
  );

  mc_cache_store #(
    .sets_p(sets_p),
    .ways_p(ways_p),
    .block_size_in_words_p(block_size_in_words_p)
  ) cache (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .pkt_i(cache_pkt),
    .v_i(cache_pkt_v),
    .ready_o(cache_ready),
    .data_o(cache_data),
    .v_o(cache_v),
    .yumi_i(cache_yumi),
    .v_we_o(cache_v_we)
  );

endmodule

`default_nettype wire

// File: logic/mc_link_to_cache.sv
`timescale 1ns/1ps
`default_nettype none

module mc_link_to_cache #(
  parameter int sets_p = 4,
  parameter int ways_p = 2,
  parameter int block_size_in_words_p = 4
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  mc_cache_pkg::mc_request_s              req_i,
  input  logic                                   req_v_i,
  output logic                                   req_yumi_o,
  output mc_cache_pkg::cache_pkt_s               cache_pkt_o,
  output logic                                   v_o,
  input  logic                                   ready_i,
  input  logic [mc_cache_pkg::data_width_gp-1:0] data_i,
  input  logic                                   v_i,
  output logic                                   yumi_o,
  input  logic                                   v_we_i,
  output mc_cache_pkg::mc_return_s               ret_o,
  output logic                                   ret_v_o,
  input  logic                                   ret_ready_i
);
  import mc_cache_pkg::*;

  localparam int tag_total_lp = sets_p * ways_p;
  localparam int lg_tags_lp = (tag_total_lp > 1) ? $clog2(tag_total_lp) : 1;
  localparam int cnt_width_lp = $clog2(tag_total_lp + 1);
  localparam int block_offset_width_lp =
    $clog2(mask_width_gp) + $clog2(block_size_in_words_p);

  typedef enum logic [1:0] {
    RESET,
    CLEAR_TAG,
    READY
  } state_e;

  // who asked, per cache stage
  typedef struct packed {
    ret_type_e pkt_type;
    logic [reg_id_width_gp-1:0] reg_id;
    logic [cord_width_gp-1:0] src_x;
    logic [cord_width_gp-1:0] src_y;
  } track_s;

  state_e state_r, state_n;
  logic [cnt_width_lp-1:0] tagst_sent_r, tagst_sent_n;
  logic [cnt_width_lp-1:0] tagst_recv_r, tagst_recv_n;
  track_s tl_info_r, tv_info_r;
  ret_type_e ret_type;
  cache_opcode_e req_opcode;

  always_comb begin
    unique case (req_i.op)
      e_mc_load: begin
        if (req_i.load_info.icache_fetch) begin
          ret_type = e_ret_ifetch;
        end else if (req_i.load_info.float_wb) begin
          ret_type = e_ret_float_wb;
        end else begin
          ret_type = e_ret_int_wb;
        end
      end
      e_mc_amoswap, e_mc_amoor: ret_type = e_ret_int_wb;
      default: ret_type = e_ret_credit;
    endcase
  end

  // top address bit maps onto the tag memory
  always_comb begin
    if (req_i.addr[addr_width_gp-1]) begin
      case (req_i.op)
        e_mc_store, e_mc_sw: req_opcode = TAGST;
        e_mc_cache_op: req_opcode = TAGFL;
        default: req_opcode = TAGLA;
      endcase
    end else begin
      case (req_i.op)
        e_mc_store, e_mc_sw: req_opcode = SM;
        e_mc_amoswap: req_opcode = AMOSWAP_W;
        e_mc_amoor: req_opcode = AMOOR_W;
        e_mc_cache_op: begin
          case (req_i.cache_op)
            e_aflinv: req_opcode = AFLINV;
            e_ainv: req_opcode = AINV;
            default: req_opcode = AFL;
          endcase
        end
        e_mc_load: begin
          if (req_i.load_info.is_byte_op) begin
            req_opcode = req_i.load_info.is_unsigned_op ? LBU : LB;
          end else if (req_i.load_info.is_hex_op) begin
            req_opcode = req_i.load_info.is_unsigned_op ? LHU : LH;
          end else begin
            req_opcode = LW;
          end
        end
        default: req_opcode = AFL;
      endcase
    end
  end

  always_comb begin
    state_n = state_r;
    tagst_sent_n = tagst_sent_r;
    tagst_recv_n = tagst_recv_r;
    cache_pkt_o = '0;
    cache_pkt_o.opcode = TAGST;
    v_o = 1'b0;
    yumi_o = 1'b0;
    req_yumi_o = 1'b0;
    ret_v_o = 1'b0;

    case (state_r)
      RESET: begin
        state_n = CLEAR_TAG;
      end
      CLEAR_TAG: begin
        v_o = (tagst_sent_r != cnt_width_lp'(tag_total_lp));
        cache_pkt_o.addr[block_offset_width_lp+:lg_tags_lp] = tagst_sent_r[lg_tags_lp-1:0];
        if (v_o & ready_i) begin
          tagst_sent_n = tagst_sent_r + 1'b1;
        end
        // tag store answers carry nothing useful
        yumi_o = v_i;
        if (v_i) begin
          tagst_recv_n = tagst_recv_r + 1'b1;
        end
        if ((tagst_sent_r == cnt_width_lp'(tag_total_lp))
            && (tagst_recv_r == cnt_width_lp'(tag_total_lp))) begin
          state_n = READY;
        end
      end
      READY: begin
        v_o = req_v_i;
        req_yumi_o = req_v_i & ready_i;
        cache_pkt_o.opcode = req_opcode;
        cache_pkt_o.data = req_i.payload;
        cache_pkt_o.mask = (req_i.op == e_mc_sw) ? '1 : req_i.mask;
        cache_pkt_o.addr = {
          req_i.addr,
          (req_i.op == e_mc_load) ? req_i.load_info.part_sel : 2'b00
        };
        ret_v_o = v_i;
        yumi_o = v_i & ret_ready_i;
      end
      default: begin
        state_n = READY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_yumi_o) begin
      tl_info_r <= '{
        pkt_type: ret_type,
        reg_id: req_i.reg_id,
        src_x: req_i.src_x,
        src_y: req_i.src_y
      };
    end
    if (v_we_i) begin
      tv_info_r <= tl_info_r;
    end
  end

  assign ret_o = '{
    pkt_type: tv_info_r.pkt_type,
    data: data_i,
    reg_id: tv_info_r.reg_id,
    src_x: tv_info_r.src_x,
    src_y: tv_info_r.src_y
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RESET;
      tagst_sent_r <= '0;
      tagst_recv_r <= '0;
    end else begin
      state_r <= state_n;
      tagst_sent_r <= tagst_sent_n;
      tagst_recv_r <= tagst_recv_n;
    end
  end

endmodule

`default_nettype wire

// File: logic/mc_request_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mc_request_fifo #(
  parameter int els_p = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mc_cache_pkg::mc_request_s data_i,
  input  logic                      v_i,
  output logic                      ready_o,
  output mc_cache_pkg::mc_request_s data_o,
  output logic                      v_o,
  input  logic                      yumi_i
);
  import mc_cache_pkg::*;

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  mc_request_s mem [els_p];
  logic [ptr_width_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic enq, deq;

  // a full buffer still takes a write when the head leaves
  assign ready_o = (count_r != cnt_width_lp'(els_p)) | yumi_i;
  assign v_o = (count_r != '0);
  assign data_o = mem[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + cnt_width_lp'(enq) - cnt_width_lp'(deq);
    end
  end

endmodule

`default_nettype wire

// File: tests/mc_cache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mc_cache_chk #(
  parameter int tags_p = 8
) (
  input logic clk_i,
  input logic reset_i,
  input logic req_v_i,
  input logic req_yumi_i,
  input logic pkt_v_i,
  input logic pkt_ready_i,
  input logic cache_v_i,
  input logic cache_yumi_i,
  input logic v_we_i,
  input logic ret_v_i,
  input logic ret_ready_i
);

  int fail_count = 0;
  logic tl_busy_r;
  int answers_r;

  // shadow of the lookup-stage occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_busy_r <= 1'b0;
    end else if (pkt_v_i & pkt_ready_i) begin
      tl_busy_r <= 1'b1;
    end else if (v_we_i) begin
      tl_busy_r <= 1'b0;
    end
  end

  // cache answers since reset, the tag stores come first
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      answers_r <= 0;
    end else if (cache_v_i & cache_yumi_i & (answers_r < tags_p)) begin
      answers_r <= answers_r + 1;
    end
  end

  take_after_clear: assert property (@(posedge clk_i) disable iff (reset_i)
    req_yumi_i |-> (answers_r == tags_p))
    else begin
      $error("request taken before every tag store was answered");
      fail_count = fail_count + 1;
    end

  req_v_held: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i & ~req_yumi_i |=> req_v_i)
    else begin
      $error("fifo valid dropped without yumi");
      fail_count = fail_count + 1;
    end

  pkt_v_held: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_v_i & ~pkt_ready_i |=> pkt_v_i)
    else begin
      $error("cache packet valid dropped without ready");
      fail_count = fail_count + 1;
    end

  cache_v_held: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_v_i & ~cache_yumi_i |=> cache_v_i)
    else begin
      $error("cache valid dropped without yumi");
      fail_count = fail_count + 1;
    end

  ret_v_held: assert property (@(posedge clk_i) disable iff (reset_i)
    ret_v_i & ~ret_ready_i |=> ret_v_i)
    else begin
      $error("return valid dropped without ready");
      fail_count = fail_count + 1;
    end

  v_we_with_item: assert property (@(posedge clk_i) disable iff (reset_i)
    v_we_i |-> tl_busy_r)
    else begin
      $error("v_we without a lookup-stage item");
      fail_count = fail_count + 1;
    end

endmodule

bind mc_link_to_cache mc_cache_chk #(
  .tags_p(sets_p * ways_p)
) chk (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .req_v_i(req_v_i),
  .req_yumi_i(req_yumi_o),
  .pkt_v_i(v_o),
  .pkt_ready_i(ready_i),
  .cache_v_i(v_i),
  .cache_yumi_i(yumi_o),
  .v_we_i(v_we_i),
  .ret_v_i(ret_v_o),
  .ret_ready_i(ret_ready_i)
);

`default_nettype wire

// File: tests/tb_mc_cache_tile.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mc_cache_tile;
  import mc_cache_pkg::*;

  localparam int sets_lp = 4;
  localparam int ways_lp = 2;
  localparam int block_lp = 4;
  localparam int tags_lp = sets_lp * ways_lp;
  localparam int words_lp = tags_lp * block_lp;
  localparam int max_tests_lp = 128;
  localparam int reset_cycles_lp = 5;
  localparam int clear_cycles_lp = reset_cycles_lp + 4 * tags_lp + 8;

  logic clk_i = 1'b0;
  logic reset_i;
  mc_request_s req_i;
  logic req_v_i, req_ready_o;
  mc_return_s ret_o;
  logic ret_v_o, ret_ready_i;

  mc_request_s req_tbl [max_tests_lp];
  mc_return_s exp_tbl [max_tests_lp];
  logic [data_width_gp-1:0] ref_mem [words_lp];
  logic [data_width_gp-1:0] ref_tag [tags_lp];
  int n_tests = 0;
  int recv_cnt = 0;
  int data_errors = 0;
  int header_errors = 0;
  int other_errors = 0;
  int total_errors;
  integer seed;
  logic table_ready = 1'b0;

  mc_cache_tile #(
    .sets_p(sets_lp),
    .ways_p(ways_lp),
    .block_size_in_words_p(block_lp),
    .fifo_els_p(4)
  ) dut (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_i(req_i),
    .req_v_i(req_v_i),
    .req_ready_o(req_ready_o),
    .ret_o(ret_o),
    .ret_v_o(ret_v_o),
    .ret_ready_i(ret_ready_i)
  );

  always #4 clk_i = ~clk_i;

  function automatic load_info_s make_load_info(input logic fetch, input logic fwb,
      input logic is_byte, input logic is_hex, input logic is_uns, input int ps);
    load_info_s li;
    li = '0;
    li.icache_fetch = fetch;
    li.float_wb = fwb;
    li.is_byte_op = is_byte;
    li.is_hex_op = is_hex;
    li.is_unsigned_op = is_uns;
    li.part_sel = ps[1:0];
    return li;
  endfunction

  function automatic logic [addr_width_gp-1:0] tag_addr(input int t);
    return 12'h800 | 12'(t * block_lp);
  endfunction

  function automatic ret_type_e load_ret_type(input load_info_s li);
    if (li.icache_fetch) begin
      return e_ret_ifetch;
    end
    return li.float_wb ? e_ret_float_wb : e_ret_int_wb;
  endfunction

  // byte at part_sel, half aligned to part_sel
  function automatic logic [31:0] load_value(input logic [31:0] word, input load_info_s li);
    logic [7:0] b;
    logic [15:0] h;
    b = word[8*li.part_sel+:8];
    h = word[16*li.part_sel[1]+:16];
    if (li.is_byte_op) begin
      return li.is_unsigned_op ? {24'h0, b} : {{24{b[7]}}, b};
    end
    if (li.is_hex_op) begin
      return li.is_unsigned_op ? {16'h0, h} : {{16{h[15]}}, h};
    end
    return word;
  endfunction

  task automatic add_request(input mc_op_e op, input logic [addr_width_gp-1:0] addr,
      input logic [31:0] payload, input logic [3:0] mask, input cache_op_e cop,
      input load_info_s li);
    mc_request_s r;
    mc_return_s e;
    int w;
    int t;
    logic [31:0] old;
    r = '0;
    r.op = op;
    r.addr = addr;
    r.payload = payload;
    r.mask = mask;
    r.reg_id = n_tests[4:0];
    r.cache_op = cop;
    r.load_info = li;
    r.src_x = n_tests[3:0];
    r.src_y = ~n_tests[7:4];
    e = '0;
    e.pkt_type = e_ret_credit;
    e.reg_id = r.reg_id;
    e.src_x = r.src_x;
    e.src_y = r.src_y;
    w = int'(addr[addr_width_gp-2:0]) % words_lp;
    t = (int'(addr[addr_width_gp-2:0]) / block_lp) % tags_lp;
    old = ref_mem[w];
    if (addr[addr_width_gp-1]) begin
      if (op == e_mc_store || op == e_mc_sw) begin
        ref_tag[t] = payload;
      end else if (op == e_mc_load) begin
        e.pkt_type = load_ret_type(li);
        e.data = ref_tag[t];
      end
    end else begin
      case (op)
        e_mc_store: begin
          for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
              ref_mem[w][8*b+:8] = payload[8*b+:8];
            end
          end
        end
        e_mc_sw: ref_mem[w] = payload;
        e_mc_load: begin
          e.pkt_type = load_ret_type(li);
          e.data = load_value(old, li);
        end
        e_mc_amoswap: begin
          e.pkt_type = e_ret_int_wb;
          e.data = old;
          ref_mem[w] = payload;
        end
        e_mc_amoor: begin
          e.pkt_type = e_ret_int_wb;
          e.data = old;
          ref_mem[w] = old | payload;
        end
        default: ;
      endcase
    end
    req_tbl[n_tests] = r;
    exp_tbl[n_tests] = e;
    n_tests = n_tests + 1;
  endtask

  task automatic build_table();
    load_info_s li0;
    logic [addr_width_gp-1:0] w;
    li0 = '0;
    for (int i = 0; i < words_lp; i++) begin
      ref_mem[i] = '0;
    end
    for (int i = 0; i < tags_lp; i++) begin
      ref_tag[i] = '0;
      add_request(e_mc_load, tag_addr(i), '0, '0, e_afl, li0);
    end
    add_request(e_mc_store, tag_addr(3), 32'h0000_05a5, 4'hf, e_afl, li0);
    add_request(e_mc_sw, tag_addr(6), 32'h0000_0c3c, 4'h0, e_afl, li0);
    add_request(e_mc_load, tag_addr(3), '0, '0, e_afl, li0);
    add_request(e_mc_load, tag_addr(6), '0, '0, e_afl, li0);
    add_request(e_mc_load, tag_addr(0), '0, '0, e_afl, li0);
    // full word then masked bytes, then every load width
    for (int k = 0; k < 2; k++) begin
      w = (k == 0) ? 12'd5 : 12'd22;
      add_request(e_mc_sw, w, (k == 0) ? 32'h8a7f_01f3 : $random(seed), 4'h0, e_afl, li0);
      add_request(e_mc_store, w, (k == 0) ? 32'hc593_6e22 : $random(seed),
                  (k == 0) ? 4'b0101 : 4'b1010, e_afl, li0);
      add_request(e_mc_load, w, '0, '0, e_afl, li0);
      for (int ps = 0; ps < 4; ps++) begin
        add_request(e_mc_load, w, '0, '0, e_afl, make_load_info(0, 0, 1, 0, 0, ps));
        add_request(e_mc_load, w, '0, '0, e_afl, make_load_info(0, 0, 1, 0, 1, ps));
        add_request(e_mc_load, w, '0, '0, e_afl, make_load_info(0, 0, 0, 1, 0, ps));
        add_request(e_mc_load, w, '0, '0, e_afl, make_load_info(0, 0, 0, 1, 1, ps));
      end
    end
    for (int f = 0; f < 4; f++) begin
      add_request(e_mc_load, 12'd5, '0, '0, e_afl, make_load_info(f[1], f[0], 0, 0, 0, 0));
    end
    add_request(e_mc_amoswap, 12'd5, 32'h1234_0f0f, '0, e_afl, li0);
    add_request(e_mc_load, 12'd5, '0, '0, e_afl, li0);
    add_request(e_mc_amoor, 12'd5, 32'h8000_f000, '0, e_afl, li0);
    add_request(e_mc_load, 12'd5, '0, '0, e_afl, li0);
    add_request(e_mc_cache_op, 12'd5, '0, '0, e_afl, li0);
    add_request(e_mc_cache_op, 12'd5, '0, '0, e_aflinv, li0);
    add_request(e_mc_cache_op, 12'd22, '0, '0, e_ainv, li0);
    add_request(e_mc_cache_op, tag_addr(2), '0, '0, e_afl, li0);
    for (int k = 0; k < 8; k++) begin
      w = 12'($unsigned($random(seed)) % words_lp);
      add_request(e_mc_sw, w, $random(seed), '0, e_afl, li0);
      add_request(e_mc_load, w, '0, '0, e_afl, li0);
    end
  endtask

  // random back-pressure on the return port
  always @(negedge clk_i) begin
    ret_ready_i = (($random(seed) & 3) != 0);
  end

  always @(posedge clk_i) begin
    if (!reset_i && ret_v_o && ret_ready_i) begin
      if (recv_cnt >= n_tests) begin
        $display("%0t: a return arrived after every request was already answered", $time);
        other_errors = other_errors + 1;
      end else begin
        if (ret_o.data !== exp_tbl[recv_cnt].data) begin
          $display("ERROR %0t: return %0d data %h, expected %h", $time, recv_cnt,
                   ret_o.data, exp_tbl[recv_cnt].data);
          data_errors = data_errors + 1;
        end
        if (ret_o.pkt_type !== exp_tbl[recv_cnt].pkt_type
            || ret_o.reg_id !== exp_tbl[recv_cnt].reg_id
            || ret_o.src_x !== exp_tbl[recv_cnt].src_x
            || ret_o.src_y !== exp_tbl[recv_cnt].src_y) begin
          $display("ERROR %0t: return %0d type %0d reg %0d x %0d y %0d, expected %0d %0d %0d %0d",
                   $time, recv_cnt, ret_o.pkt_type, ret_o.reg_id, ret_o.src_x, ret_o.src_y,
                   exp_tbl[recv_cnt].pkt_type, exp_tbl[recv_cnt].reg_id,
                   exp_tbl[recv_cnt].src_x, exp_tbl[recv_cnt].src_y);
          header_errors = header_errors + 1;
        end
        recv_cnt = recv_cnt + 1;
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (n_tests * 40 + clear_cycles_lp) @(posedge clk_i);
    $display("timeout: only %0d of %0d returns arrived", recv_cnt, n_tests);
    $display("Test failed");
    $finish;
  end

  initial begin
    reset_i = 1'b1;
    req_i = '0;
    req_v_i = 1'b0;
    ret_ready_i = 1'b1;
    seed = 3;
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;
    @(posedge clk_i);
    if (ret_v_o !== 1'b0) begin
      $display("ERROR %0t: ret_v_o high right after reset", $time);
      other_errors = other_errors + 1;
    end
    for (int i = 0; i < n_tests; i++) begin
      @(negedge clk_i);
      req_i = req_tbl[i];
      req_v_i = 1'b1;
      @(posedge clk_i);
      while (!req_ready_o) begin
        @(posedge clk_i);
      end
    end
    @(negedge clk_i);
    req_v_i = 1'b0;
    wait (recv_cnt == n_tests);
    repeat (10) @(posedge clk_i);
    total_errors = data_errors + header_errors + other_errors + dut.link.chk.fail_count;
    $display("errors: %0d data, %0d header, %0d other, %0d assertion",
             data_errors, header_errors, other_errors, dut.link.chk.fail_count);
    if (total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
